/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_bcu
FILELIST  ?= bcu_sub.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUN_FLAGS ?= +verilator+error+limit+1000
PASS_TEXT ?= PASS: all tests

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS))"; \
		echo "$$out"; \
		echo "$$out" | grep -qxF "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

/* bcu_sub.f */
design/bcu_pkg.sv
design/bcu_lane_steer.sv
design/bcu_write_buffer.sv
design/bcu_mem_sequencer.sv
design/bcu_top.sv
verif/tb_mem_model.sv
verif/bcu_checker.sv
verif/tb_bcu.sv

/* design/bcu_lane_steer.sv */
// byte stores take wr_data[7:0] only; wr_size 0 is a byte, 1 a word; one register stage
`timescale 1ns/100ps
`default_nettype none

module bcu_lane_steer import bcu_pkg::*; (
	input  logic              sys_clk,
	input  logic              arst_n,
	input  logic              wr_valid,     // one pulse per store
	input  logic [addr_w-1:0] wr_addr,
	input  logic              wr_size,
	input  logic [data_w-1:0] wr_data,
	output logic              steer_valid,
	output logic [addr_w-1:0] steer_addr,   // word aligned
	output logic [data_w-1:0] steer_data,
	output logic [mask_w-1:0] steer_mask
);

	// ----------------------------------------
	// valid stage
	// ----------------------------------------
	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			steer_valid <= 1'b0;
		end else begin
			steer_valid <= wr_valid;        // t -> t+1
		end
	end

	// ----------------------------------------
	// payload and lane placement
	// ----------------------------------------
	always_ff @(posedge sys_clk) begin
		if (wr_valid) begin
			// byte select now lives in the mask
			steer_addr <= {wr_addr[addr_w-1:2], 2'b00};
			if (wr_size) begin
				steer_data <= wr_data;                        // word as is
				steer_mask <= '1;
			end else begin
				steer_data <= {mask_w{wr_data[7:0]}};         // byte on every lane
				steer_mask <= {{(mask_w-1){1'b0}}, 1'b1} << wr_addr[1:0];
			end
		end
	end

endmodule

`default_nettype wire

/* design/bcu_mem_sequencer.sv */
// one memory transaction at a time; a D-cache read waits for an empty write buffer
`timescale 1ns/100ps
`default_nettype none

module bcu_mem_sequencer import bcu_pkg::*; (
	input  logic              sys_clk,
	input  logic              arst_n,
	input  logic              icache_req,
	input  logic [addr_w-1:0] icache_addr,
	input  logic              dcache_req,
	input  logic [addr_w-1:0] dcache_addr,
	input  logic              start_shutdown,
	input  logic              wb_nonempty,
	input  logic [addr_w-1:0] wb_addr,
	input  logic [data_w-1:0] wb_data,
	input  logic [mask_w-1:0] wb_mask,
	input  logic [data_w-1:0] mem_rdata,
	input  logic              mem_rvalid,
	input  logic              mem_ack,
	output logic [data_w-1:0] cache_rdata,   // shared by both caches
	output logic              icache_rvalid,
	output logic              dcache_rvalid,
	output logic              icache_done,
	output logic              dcache_done,
	output logic              wb_pop,
	output mem_cmd_t          mem_cmd,
	output logic [addr_w-1:0] mem_addr,
	output logic [data_w-1:0] mem_wdata,
	output logic [mask_w-1:0] mem_wmask,
	output logic              shutdown_done
);

	customer_t state;

	logic              ipend;              // icache request waiting
	logic              dpend;
	logic [addr_w-1:0] iaddr_q;
	logic [addr_w-1:0] daddr_q;
	logic              shut_req;           // shutdown seen
	logic [$clog2(line_beats)-1:0] beat_cnt;

	logic              shut_now;
	logic              want_i;
	logic              want_d;
	logic              want_w;
	logic [addr_w-1:0] iaddr_sel;
	logic [addr_w-1:0] daddr_sel;
	logic              last_beat;

	function automatic logic [addr_w-1:0] align_line(input logic [addr_w-1:0] a);
		return {a[addr_w-1:line_off_w], {line_off_w{1'b0}}};
	endfunction

	// ----------------------------------------
	// arbitration, fixed priority
	// ----------------------------------------
	assign shut_now  = shut_req | start_shutdown;     // reads die in the pulse cycle too
	assign want_i    = ~shut_now & (ipend | icache_req);
	assign want_d    = ~shut_now & (dpend | dcache_req) & ~wb_nonempty;  // stores first
	assign want_w    = wb_nonempty;
	assign iaddr_sel = icache_req ? icache_addr : iaddr_q;
	assign daddr_sel = dcache_req ? dcache_addr : daddr_q;
	assign last_beat = mem_rvalid & (beat_cnt == ($clog2(line_beats))'(line_beats - 1));

	assign wb_pop = (state == cust_dwrite) & mem_ack;  // entry is in memory

	// done as soon as nothing is left to drain
	assign shutdown_done = (state == cust_halted) |
		(shut_req & (state == cust_none) & ~wb_nonempty);

	// ----------------------------------------
	// control state
	// ----------------------------------------
	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			state         <= cust_none;
			ipend         <= 1'b0;
			dpend         <= 1'b0;
			shut_req      <= 1'b0;
			beat_cnt      <= '0;
			icache_rvalid <= 1'b0;
			dcache_rvalid <= 1'b0;
			icache_done   <= 1'b0;
			dcache_done   <= 1'b0;
			mem_cmd       <= cmd_idle;
			mem_addr      <= '0;
			mem_wdata     <= '0;
			mem_wmask     <= '0;
		end else begin
			if (start_shutdown)
				shut_req <= 1'b1;           // sticky until reset
			if (shut_now) begin
				ipend <= 1'b0;              // drop reads not yet started
				dpend <= 1'b0;
			end else begin
				if (icache_req)
					ipend <= 1'b1;
				if (dcache_req)
					dpend <= 1'b1;
			end

			// beat return, one cycle behind memory
			icache_rvalid <= mem_rvalid & (state == cust_ifetch);
			dcache_rvalid <= mem_rvalid & (state == cust_dread);
			icache_done   <= last_beat & (state == cust_ifetch);
			dcache_done   <= last_beat & (state == cust_dread);
			if (mem_rvalid && (state == cust_ifetch || state == cust_dread))
				beat_cnt <= beat_cnt + 1'b1;

			case (state)
				cust_none: begin
					beat_cnt <= '0;
					if (want_i) begin
						state     <= cust_ifetch;
						ipend     <= 1'b0;   // overrides the set above
						mem_cmd   <= cmd_read_line;
						mem_addr  <= align_line(iaddr_sel);
						mem_wmask <= '0;
					end else if (want_d) begin
						state     <= cust_dread;
						dpend     <= 1'b0;
						mem_cmd   <= cmd_read_line;
						mem_addr  <= align_line(daddr_sel);
						mem_wmask <= '0;
					end else if (want_w) begin
						state     <= cust_dwrite;
						mem_cmd   <= cmd_write_word;
						mem_addr  <= wb_addr;   // head held until pop
						mem_wdata <= wb_data;
						mem_wmask <= wb_mask;
					end else if (shut_now) begin
						state <= cust_halted;   // buffer drained
					end
				end
				cust_ifetch, cust_dread, cust_dwrite: begin
					if (mem_ack) begin
						state   <= cust_none;   // idle gap of at least one cycle
						mem_cmd <= cmd_idle;
					end
				end
				default: begin
					state <= cust_halted;       // halted, ignore everything
				end
			endcase
		end
	end

	// read payload, no reset needed
	always_ff @(posedge sys_clk) begin
		if (icache_req)
			iaddr_q <= icache_addr;
		if (dcache_req)
			daddr_q <= dcache_addr;
		if (mem_rvalid)
			cache_rdata <= mem_rdata;
	end

endmodule

`default_nettype wire

/* design/bcu_pkg.sv */
// bus widths and line geometry are fixed here; a bus word is 4 bytes, a line 16 bytes
`default_nettype none

package bcu_pkg;

	// ----------------------------------------
	// bus widths
	// ----------------------------------------
	localparam int addr_w = 32;       // byte address
	localparam int data_w = 32;       // memory bus and store word
	localparam int mask_w = 4;        // one mask bit per byte lane

	// ----------------------------------------
	// line and buffer geometry
	// ----------------------------------------
	localparam int line_beats = 4;    // beats per line read
	localparam int line_off_w = 4;    // 16-byte line
	localparam int wbuf_depth = 4;    // entries, also the writer's starting credits
	localparam int wbuf_ptr_w = 2;    // log2 of wbuf_depth

	// memory port command
	typedef enum logic [1:0] {
		cmd_idle       = 2'd0,
		cmd_read_line  = 2'd1,        // four beats from the line base
		cmd_write_word = 2'd2         // one masked word
	} mem_cmd_t;

	// who owns the memory port right now
	typedef enum logic [2:0] {
		cust_none   = 3'd0,
		cust_ifetch = 3'd1,
		cust_dread  = 3'd2,
		cust_dwrite = 3'd3,
		cust_halted = 3'd4            // after shutdown, left only by reset
	} customer_t;

endpackage

`default_nettype wire

/* design/bcu_top.sv */
// single clock domain; caches must not re-request before done, writer must track credits
`timescale 1ns/100ps
`default_nettype none

module bcu_top import bcu_pkg::*; (
	input  logic              sys_clk,
	input  logic              arst_n,
	// cache read side
	input  logic              icache_req,
	input  logic [addr_w-1:0] icache_addr,
	input  logic              dcache_req,
	input  logic [addr_w-1:0] dcache_addr,
	output logic [data_w-1:0] cache_rdata,
	output logic              icache_rvalid,
	output logic              dcache_rvalid,
	output logic              icache_done,
	output logic              dcache_done,
	// store side
	input  logic              wr_valid,
	input  logic [addr_w-1:0] wr_addr,
	input  logic              wr_size,
	input  logic [data_w-1:0] wr_data,
	output logic              wr_credit,
	// memory port
	output mem_cmd_t          mem_cmd,
	output logic [addr_w-1:0] mem_addr,
	output logic [data_w-1:0] mem_wdata,
	output logic [mask_w-1:0] mem_wmask,
	input  logic [data_w-1:0] mem_rdata,
	input  logic              mem_rvalid,
	input  logic              mem_ack,
	// shutdown
	input  logic              start_shutdown,
	output logic              shutdown_done
);

	// ----------------------------------------
	// internal wires
	// ----------------------------------------
	logic              steer_valid;
	logic [addr_w-1:0] steer_addr;
	logic [data_w-1:0] steer_data;
	logic [mask_w-1:0] steer_mask;
	logic              wb_nonempty;
	logic [addr_w-1:0] wb_addr;
	logic [data_w-1:0] wb_data;
	logic [mask_w-1:0] wb_mask;
	logic              wb_pop;

	bcu_lane_steer u_steer (
		.sys_clk     (sys_clk),
		.arst_n      (arst_n),
		.wr_valid    (wr_valid),
		.wr_addr     (wr_addr),
		.wr_size     (wr_size),
		.wr_data     (wr_data),
		.steer_valid (steer_valid),
		.steer_addr  (steer_addr),
		.steer_data  (steer_data),
		.steer_mask  (steer_mask)
	);

	bcu_write_buffer u_wbuf (
		.sys_clk     (sys_clk),
		.arst_n      (arst_n),
		.steer_valid (steer_valid),
		.steer_addr  (steer_addr),
		.steer_data  (steer_data),
		.steer_mask  (steer_mask),
		.wb_pop      (wb_pop),
		.wb_nonempty (wb_nonempty),
		.wb_addr     (wb_addr),
		.wb_data     (wb_data),
		.wb_mask     (wb_mask),
		.wr_credit   (wr_credit)      // straight out to the writer
	);

	bcu_mem_sequencer u_seq (
		.sys_clk        (sys_clk),
		.arst_n         (arst_n),
		.icache_req     (icache_req),
		.icache_addr    (icache_addr),
		.dcache_req     (dcache_req),
		.dcache_addr    (dcache_addr),
		.start_shutdown (start_shutdown),
		.wb_nonempty    (wb_nonempty),
		.wb_addr        (wb_addr),
		.wb_data        (wb_data),
		.wb_mask        (wb_mask),
		.mem_rdata      (mem_rdata),
		.mem_rvalid     (mem_rvalid),
		.mem_ack        (mem_ack),
		.cache_rdata    (cache_rdata),
		.icache_rvalid  (icache_rvalid),
		.dcache_rvalid  (dcache_rvalid),
		.icache_done    (icache_done),
		.dcache_done    (dcache_done),
		.wb_pop         (wb_pop),
		.mem_cmd        (mem_cmd),
		.mem_addr       (mem_addr),
		.mem_wdata      (mem_wdata),
		.mem_wmask      (mem_wmask),
		.shutdown_done  (shutdown_done)
	);

endmodule

`default_nettype wire

/* design/bcu_write_buffer.sv */
// pushes into a full buffer are dropped; the writer must stay within its credits
`timescale 1ns/100ps
`default_nettype none

module bcu_write_buffer import bcu_pkg::*; (
	input  logic              sys_clk,
	input  logic              arst_n,
	input  logic              steer_valid,
	input  logic [addr_w-1:0] steer_addr,
	input  logic [data_w-1:0] steer_data,
	input  logic [mask_w-1:0] steer_mask,
	input  logic              wb_pop,        // head reached memory
	output logic              wb_nonempty,
	output logic [addr_w-1:0] wb_addr,
	output logic [data_w-1:0] wb_data,
	output logic [mask_w-1:0] wb_mask,
	output logic              wr_credit      // one pulse per retired entry
);

	// entry storage
	logic [addr_w-1:0] addr_mem [wbuf_depth];
	logic [data_w-1:0] data_mem [wbuf_depth];
	logic [mask_w-1:0] mask_mem [wbuf_depth];

	logic [wbuf_ptr_w-1:0] wr_ptr;
	logic [wbuf_ptr_w-1:0] rd_ptr;
	logic [wbuf_ptr_w:0]   count;           // 0..wbuf_depth
	logic                  push;
	logic                  pop;

	assign push = steer_valid & (count != (wbuf_ptr_w + 1)'(wbuf_depth));
	assign pop  = wb_pop & wb_nonempty;

	// head of queue straight to the sequencer
	assign wb_nonempty = (count != '0);
	assign wb_addr     = addr_mem[rd_ptr];
	assign wb_data     = data_mem[rd_ptr];
	assign wb_mask     = mask_mem[rd_ptr];

	// ----------------------------------------
	// pointers, occupancy, credit
	// ----------------------------------------
	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			count     <= '0;
			wr_credit <= 1'b0;
		end else begin
			wr_credit <= pop;               // credit back one cycle after mem_ack
			if (push)
				wr_ptr <= wr_ptr + 1'b1;    // wraps at depth
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;    // both or neither
			endcase
		end
	end

	// entry write
	always_ff @(posedge sys_clk) begin
		if (push) begin
			addr_mem[wr_ptr] <= steer_addr;
			data_mem[wr_ptr] <= steer_data;
			mask_mem[wr_ptr] <= steer_mask;
		end
	end

endmodule

`default_nettype wire

/* verif/bcu_checker.sv */
// bound into bcu_top; follows the write buffer occupancy from steer_valid and wb_pop inside it
`timescale 1ns/100ps
`default_nettype none

module bcu_checker import bcu_pkg::*; (
	input logic              sys_clk,
	input logic              arst_n,
	input logic              wr_valid,
	input logic              steer_valid,   // push into the write buffer
	input logic              wb_pop,        // head retired to memory
	input mem_cmd_t          mem_cmd,
	input logic [addr_w-1:0] mem_addr,
	input logic              mem_ack,
	input logic              icache_rvalid,
	input logic              dcache_rvalid,
	input logic              shutdown_done
);

	int occupancy;           // entries held in the write buffer
	int violations = 0;      // summed into the closing line

	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n)
			occupancy <= 0;
		else
			occupancy <= occupancy + int'(steer_valid) - int'(wb_pop);
	end

	// ----------------------------------------
	// store credits
	// ----------------------------------------
	// a store lands in the buffer one cycle after wr_valid
	a_credit: assert property (@(posedge sys_clk) disable iff (!arst_n)
		wr_valid |=> occupancy < wbuf_depth)
		else begin
			$error("store pushed into a full write buffer");
			violations++;
		end

	// ----------------------------------------
	// memory port
	// ----------------------------------------
	a_hold: assert property (@(posedge sys_clk) disable iff (!arst_n)
		(mem_cmd != cmd_idle && !mem_ack) |=> ($stable(mem_cmd) && $stable(mem_addr)))
		else begin
			$error("memory command or address changed before mem_ack");
			violations++;
		end

	a_one_reader: assert property (@(posedge sys_clk) disable iff (!arst_n)
		!(icache_rvalid && dcache_rvalid))
		else begin
			$error("both caches got a beat in the same cycle");
			violations++;
		end

	// halted means quiet for good
	a_halted: assert property (@(posedge sys_clk) disable iff (!arst_n)
		shutdown_done |-> (mem_cmd == cmd_idle) ##1 shutdown_done)
		else begin
			$error("memory command after shutdown_done, or shutdown_done dropped");
			violations++;
		end

endmodule

bind bcu_top bcu_checker chk (.*);

`default_nettype wire

/* verif/tb_bcu.sv */
// single clock; inputs driven 1 ns after the rising edge; memory stalls come from the model
`timescale 1ns/100ps
`default_nettype none

module tb_bcu import bcu_pkg::*; ();

	localparam int timeout_cycles = 60 * 40 + 1600;   // ~60 transactions, 40 cycles worst

	logic              sys_clk;
	logic              arst_n;
	logic              icache_req;
	logic [addr_w-1:0] icache_addr;
	logic              dcache_req;
	logic [addr_w-1:0] dcache_addr;
	logic [data_w-1:0] cache_rdata;
	logic              icache_rvalid;
	logic              dcache_rvalid;
	logic              icache_done;
	logic              dcache_done;
	logic              wr_valid;
	logic [addr_w-1:0] wr_addr;
	logic              wr_size;
	logic [data_w-1:0] wr_data;
	logic              wr_credit;
	mem_cmd_t          mem_cmd;
	logic [addr_w-1:0] mem_addr;
	logic [data_w-1:0] mem_wdata;
	logic [mask_w-1:0] mem_wmask;
	logic [data_w-1:0] mem_rdata;
	logic              mem_rvalid;
	logic              mem_ack;
	logic              start_shutdown;
	logic              shutdown_done;

	logic [data_w-1:0] ref_mem [logic [addr_w-3:0]];   // reference, merged at store time
	logic [addr_w-1:0] exp_addr [$];                   // steered stores still to reach memory
	logic [data_w-1:0] exp_data [$];
	logic [mask_w-1:0] exp_mask [$];
	logic [addr_w-1:0] ibase;
	logic [addr_w-1:0] dbase;
	int                errors = 0;
	int                credits = wbuf_depth;          // writer side count
	int                credit_pulses = 0;
	int                cyc = 0;
	int                ibeat = 0;
	int                dbeat = 0;
	bit                idone = 0;
	bit                ddone = 0;
	bit                reads_dead = 0;                // set once shutdown drops reads
	time               last_i_time = 0;
	time               first_d_time = 0;

	bcu_top dut (.*);
	tb_mem_model mem (.*);

	initial begin
		sys_clk = 1'b0;
		forever #5 sys_clk = ~sys_clk;
	end

	task automatic step();
		@(posedge sys_clk);
		#1;
	endtask

	task automatic report_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		$display("ERROR %s got %h expected %h at %0t", name, got, exp, $time);
		errors++;
	endtask

	task automatic report_event(input string what);
		$display("%s at %0t", what, $time);
		errors++;
	endtask

	function automatic logic [data_w-1:0] ref_word(input logic [addr_w-1:0] a);
		if (ref_mem.exists(a[addr_w-1:2]))
			return ref_mem[a[addr_w-1:2]];
		return {2'b00, a[addr_w-1:2]} ^ 32'h5a5a_0000;   // unwritten pattern
	endfunction

	// ----------------------------------------
	// stimulus tasks
	// ----------------------------------------
	task automatic store(input logic [addr_w-1:0] a, input logic sz,
		input logic [data_w-1:0] d);
		logic [data_w-1:0] lanes;
		logic [mask_w-1:0] mask;
		logic [data_w-1:0] w;
		while (credits == 0)
			step();                                 // wait for a credit back
		lanes = sz ? d : {mask_w{d[7:0]}};        // byte goes to every lane
		mask  = sz ? 4'hf : 4'b0001 << a[1:0];
		w = ref_word(a);
		for (int i = 0; i < mask_w; i++) begin
			if (mask[i])
				w[8*i +: 8] = lanes[8*i +: 8];
		end
		ref_mem[a[addr_w-1:2]] = w;
		exp_addr.push_back({a[addr_w-1:2], 2'b00});
		exp_data.push_back(lanes);
		exp_mask.push_back(mask);
		credits--;
		wr_valid = 1'b1;
		wr_addr  = a;
		wr_size  = sz;
		wr_data  = d;
		step();
		wr_valid = 1'b0;
	endtask

	// raise a request for this cycle, expected beats from the line base
	task automatic arm_line(input bit icache, input logic [addr_w-1:0] a);
		if (icache) begin
			ibase       = {a[addr_w-1:line_off_w], {line_off_w{1'b0}}};
			ibeat       = 0;
			idone       = 0;
			icache_req  = 1'b1;
			icache_addr = a;
		end else begin
			dbase       = {a[addr_w-1:line_off_w], {line_off_w{1'b0}}};
			dbeat       = 0;
			ddone       = 0;
			dcache_req  = 1'b1;
			dcache_addr = a;
		end
	endtask

	task automatic drop_requests();
		step();
		icache_req = 1'b0;
		dcache_req = 1'b0;
	endtask

	task automatic read_line(input bit icache, input logic [addr_w-1:0] a);
		arm_line(icache, a);
		drop_requests();
		while (icache ? !idone : !ddone)
			step();
	endtask

	// all stores written to memory, plus the cycle the last credit needs
	task automatic drain();
		while (exp_addr.size() != 0)
			step();
		step();                                 // credit trails mem_ack by a cycle
	endtask

	// back-to-back stores, then count the credits that came back
	task automatic burst(input logic [addr_w-1:0] base, input int n, input logic sz);
		int start;
		drain();
		start = credit_pulses;
		for (int i = 0; i < n; i++)
			store(base + addr_w'(sz ? 4 * i : i), sz, 32'h7700_0000 + 32'(17 * i + 3));
		drain();
		assert (credit_pulses - start == n)
			else report_value("wr_credit pulses", credit_pulses - start, n);
	endtask

	// ----------------------------------------
	// monitors
	// ----------------------------------------
	always @(posedge sys_clk) begin
		cyc++;
		if (cyc >= timeout_cycles) begin
			$display("timeout: run did not finish within %0d cycles", timeout_cycles);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	always @(posedge sys_clk) begin
		if (!arst_n) begin
			assert (mem_cmd == cmd_idle && mem_wmask == '0 && !shutdown_done && !wr_credit
				&& !icache_rvalid && !dcache_rvalid && !icache_done && !dcache_done)
				else report_event("outputs not quiet in reset");
		end else begin
			if (wr_credit) begin
				credits++;
				credit_pulses++;
			end
			assert (!(reads_dead && (icache_rvalid || dcache_rvalid)))
				else report_event("read beat returned after its request was dropped");
			assert (icache_done == (icache_rvalid && ibeat == line_beats - 1))
				else report_value("icache_done", icache_done, ~icache_done);
			assert (dcache_done == (dcache_rvalid && dbeat == line_beats - 1))
				else report_value("dcache_done", dcache_done, ~dcache_done);
			if (icache_rvalid) begin
				assert (cache_rdata == ref_word(ibase + addr_w'(4 * ibeat)))
					else report_value("cache_rdata", cache_rdata,
						ref_word(ibase + addr_w'(4 * ibeat)));
				last_i_time = $time;
				ibeat++;
				idone = icache_done;
			end
			if (dcache_rvalid) begin
				assert (cache_rdata == ref_word(dbase + addr_w'(4 * dbeat)))
					else report_value("cache_rdata", cache_rdata,
						ref_word(dbase + addr_w'(4 * dbeat)));
				if (dbeat == 0)
					first_d_time = $time;
				dbeat++;
				ddone = dcache_done;
			end
			// each write at memory must be the oldest steered store
			if (mem_cmd == cmd_write_word && mem_ack) begin
				if (exp_addr.size() == 0) begin
					report_event("memory write with no store outstanding");
				end else begin
					assert (mem_addr == exp_addr[0])
						else report_value("mem_addr", mem_addr, exp_addr[0]);
					assert (mem_wmask == exp_mask[0])
						else report_value("mem_wmask", mem_wmask, exp_mask[0]);
					assert (mem_wdata == exp_data[0])
						else report_value("mem_wdata", mem_wdata, exp_data[0]);
					void'(exp_addr.pop_front());
					void'(exp_data.pop_front());
					void'(exp_mask.pop_front());
				end
			end
		end
	end

	// ----------------------------------------
	// test sequence
	// ----------------------------------------
	initial begin
		arst_n         = 1'b0;
		icache_req     = 1'b0;
		icache_addr    = '0;
		dcache_req     = 1'b0;
		dcache_addr    = '0;
		wr_valid       = 1'b0;
		wr_addr        = '0;
		wr_size        = 1'b0;
		wr_data        = '0;
		start_shutdown = 1'b0;
		repeat (16) @(posedge sys_clk);
		#1;
		arst_n = 1'b1;
		step();

		read_line(1'b1, 32'h0000_1234);                  // unaligned ifetch

		arm_line(1'b1, 32'h0000_1a08);                   // both in one cycle
		arm_line(1'b0, 32'h0000_2c04);
		drop_requests();
		while (!idone || !ddone)
			step();
		assert (last_i_time < first_d_time)
			else report_event("D-cache beat came before the last I-cache beat");

		for (int lane = 0; lane < mask_w; lane++) begin
			store(32'h0000_2004 + addr_w'(lane), 1'b0, 32'h5500_00c0 + 32'(lane));
			step();                                      // store now sits in the buffer
			read_line(1'b0, 32'h0000_2008);
		end
		store(32'h0000_2008, 1'b1, 32'hdead_beef);
		step();
		read_line(1'b0, 32'h0000_2000);
		store(32'h0000_200e, 1'b1, 32'h1234_5678);       // low bits cleared by steering
		step();
		read_line(1'b0, 32'h0000_2004);

		burst(32'h0000_3000, wbuf_depth, 1'b1);
		burst(32'h0000_3010, 2 * wbuf_depth, 1'b0);    // runs out of credits midway
		read_line(1'b0, 32'h0000_3000);
		read_line(1'b0, 32'h0000_3014);

		// shutdown with stores buffered and a read held behind them
		drain();
		store(32'h0000_4000, 1'b1, 32'hcafe_f00d);
		store(32'h0000_4005, 1'b0, 32'h0000_0099);
		store(32'h0000_400c, 1'b1, 32'h0bad_1dea);
		reads_dead = 1;
		arm_line(1'b0, 32'h0000_4000);
		drop_requests();
		start_shutdown = 1'b1;
		step();
		start_shutdown = 1'b0;
		while (!shutdown_done)
			step();
		assert (exp_addr.size() == 0)
			else report_event("buffered stores missing at memory after shutdown");
		arm_line(1'b1, 32'h0000_5000);                   // must be ignored
		arm_line(1'b0, 32'h0000_5010);
		drop_requests();
		repeat (20) step();
		assert (credits == wbuf_depth)
			else report_value("credits", credits, wbuf_depth);

		$display("errors: testbench %0d, assertions %0d", errors, dut.chk.violations);
		if (errors == 0 && dut.chk.violations == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verif/tb_mem_model.sv */
// one command at a time; 0..3 stall cycles before every beat and ack; contents survive reset
`timescale 1ns/100ps
`default_nettype none

module tb_mem_model import bcu_pkg::*; (
	input  logic              sys_clk,
	input  logic              arst_n,
	input  mem_cmd_t          mem_cmd,
	input  logic [addr_w-1:0] mem_addr,
	input  logic [data_w-1:0] mem_wdata,
	input  logic [mask_w-1:0] mem_wmask,
	output logic [data_w-1:0] mem_rdata,
	output logic              mem_rvalid,
	output logic              mem_ack
);

	logic [data_w-1:0] words [logic [addr_w-3:0]];   // sparse, keyed by word index
	logic [31:0]       lcg_state = 32'h7c95_9bed;
	logic [addr_w-1:0] base;
	logic [data_w-1:0] w;

	function automatic logic [31:0] lcg(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// unwritten words read as index xor pattern
	function automatic logic [data_w-1:0] fetch(input logic [addr_w-3:0] idx);
		if (words.exists(idx))
			return words[idx];
		return {2'b00, idx} ^ 32'h5a5a_0000;
	endfunction

	task automatic next_cycle();
		@(posedge sys_clk);
		#1;                                  // drive off the edge
	endtask

	task automatic stall();
		lcg_state = lcg(lcg_state);
		repeat (lcg_state[31:30])
			next_cycle();
	endtask

	// ----------------------------------------
	// command service loop
	// ----------------------------------------
	initial begin
		mem_rdata  = '0;
		mem_rvalid = 1'b0;
		mem_ack    = 1'b0;
		forever begin
			next_cycle();
			if (arst_n && mem_cmd == cmd_read_line) begin
				base = mem_addr;                         // line base, held by the bcu
				for (int b = 0; b < line_beats; b++) begin
					stall();
					mem_rdata  = fetch(base[addr_w-1:2] + (addr_w-2)'(b));
					mem_rvalid = 1'b1;
					mem_ack    = (b == line_beats - 1);  // ack rides the last beat
					next_cycle();
					mem_rvalid = 1'b0;
					mem_ack    = 1'b0;
				end
			end else if (arst_n && mem_cmd == cmd_write_word) begin
				stall();
				w = fetch(mem_addr[addr_w-1:2]);
				for (int i = 0; i < mask_w; i++) begin
					if (mem_wmask[i])
						w[8*i +: 8] = mem_wdata[8*i +: 8];   // byte merge
				end
				words[mem_addr[addr_w-1:2]] = w;
				mem_ack = 1'b1;
				next_cycle();
				mem_ack = 1'b0;
			end
		end
	end

endmodule

`default_nettype wire
